// File: filelist.f
src/isp_pkg.sv
src/exposure_table.sv
src/exposure_ctrl.sv
src/pixel_scaler.sv
src/luma_accum.sv
src/isp_top.sv
testbench/dram_model.sv
testbench/tb_isp.sv

// File: testbench/tb_isp.sv
`timescale 1ns/100ps

module tb_isp;
    import isp_pkg::*;

    localparam int REQ_TIMEOUT = BEATS_PER_PIC * 40;
    localparam int WATCHDOG_NS = 12 * BEATS_PER_PIC * 8 * 10;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    pic_no_t   in_pic_no;
    ratio_t    in_ratio_mode;
    logic      out_valid;
    pixel_t    out_data;
    axi_addr_t ar;
    logic      arvalid;
    logic      arready;
    beat_t     rdata;
    logic      rlast;
    logic      rvalid;
    logic      rready;
    axi_addr_t aw;
    logic      awvalid;
    logic      awready;
    w_beat_t   w;
    logic      wvalid;
    logic      wready;
    logic [1:0] bresp;
    logic      bvalid;
    logic      bready;

    int     seed   = 32'he771_9dd6;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;
    pixel_t ref_mem [NUM_PICS*PIC_BYTES];
    int     ref_cnt [NUM_PICS];

    isp_top UUT (.*);

    dram_model dram (.*);

    always #5 clk = ~clk;

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_out(input pixel_t got, input pixel_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_beat(input beat_t got, input beat_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_cnt(input div_cnt_t got, input div_cnt_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic pixel_t scaled_pixel(input pixel_t p, input ratio_t r);
        int v;
        case (r)
            2'd0: v = int'(p) / 4;
            2'd1: v = int'(p) / 2;
            2'd2: v = int'(p);
            default: v = (int'(p) * 2 > 255) ? 255 : int'(p) * 2;
        endcase
        return pixel_t'(v);
    endfunction

    function automatic beat_t dram_beat(input pic_no_t pic, input int b);
        beat_t beat;
        int    base;
        base = int'(pic) * PIC_BYTES + b * PIXELS_PER_BEAT;
        for (int k = 0; k < PIXELS_PER_BEAT; k++) begin
            beat[k*8 +: 8] = dram.mem[base + k];
        end
        return beat;
    endfunction

    function automatic beat_t ref_beat(input pic_no_t pic, input int b);
        beat_t beat;
        int    base;
        base = int'(pic) * PIC_BYTES + b * PIXELS_PER_BEAT;
        for (int k = 0; k < PIXELS_PER_BEAT; k++) begin
            beat[k*8 +: 8] = ref_mem[base + k];
        end
        return beat;
    endfunction

    // scales the reference copy and moves the count, as the engine should
    task automatic predict(input pic_no_t pic, input ratio_t r,
                           output pixel_t exp_byte, output bit zero_path);
        int base;
        int sum;
        int next;
        base      = int'(pic) * PIC_BYTES;
        zero_path = (ref_cnt[pic] == 0);
        exp_byte  = '0;
        if (!zero_path) begin
            sum = 0;
            for (int i = 0; i < PIC_BYTES; i++) begin
                ref_mem[base + i] = scaled_pixel(ref_mem[base + i], r);
                // second third of the picture is green
                if (i / (PIXELS_PER_BEAT * BEATS_PER_CHANNEL) == 1) begin
                    sum += int'(ref_mem[base + i]) / 2;
                end else begin
                    sum += int'(ref_mem[base + i]) / 4;
                end
            end
            exp_byte = pixel_t'(sum >> LUMA_SHIFT);
            next = ref_cnt[pic] + int'(r) - RATIO_UNITY;
            if (next < 0) begin
                next = 0;
            end else if (next > int'(MAX_DIV_CNT)) begin
                next = int'(MAX_DIV_CNT);
            end
            ref_cnt[pic] = next;
        end
    endtask

    task automatic load_picture(input pic_no_t pic, input bit random_fill, input pixel_t value);
        pixel_t p;
        int     base;
        base = int'(pic) * PIC_BYTES;
        for (int i = 0; i < PIC_BYTES; i++) begin
            p = random_fill ? pixel_t'($random(seed)) : value;
            dram.mem[base + i] = p;
            ref_mem[base + i]  = p;
        end
    endtask

    task automatic copy_picture(input pic_no_t src, input pic_no_t dst);
        for (int i = 0; i < PIC_BYTES; i++) begin
            dram.mem[int'(dst) * PIC_BYTES + i] = dram.mem[int'(src) * PIC_BYTES + i];
            ref_mem[int'(dst) * PIC_BYTES + i]  = ref_mem[int'(src) * PIC_BYTES + i];
        end
    endtask

    task automatic check_picture(input pic_no_t pic);
        int e0;
        e0 = errors;
        for (int b = 0; b < BEATS_PER_PIC; b++) begin
            check_beat(dram_beat(pic, b), ref_beat(pic, b),
                       $sformatf("picture %0d beat %0d", pic, b));
            if (errors != e0) begin
                break;
            end
        end
    endtask

    // only the final W beat of a burst carries last
    task automatic inspect_last_flags();
        int e0;
        e0 = errors;
        for (int b = 0; b < BEATS_PER_PIC; b++) begin
            check_bit(dram.w_last_log[b], b == BEATS_PER_PIC - 1,
                      $sformatf("w.last on beat %0d", b));
            if (errors != e0) begin
                break;
            end
        end
    endtask

    // ----------------------------------------
    // one request, entered 1 ns after an edge
    // ----------------------------------------
    task automatic run_request(input pic_no_t pic, input ratio_t r, output pixel_t got);
        pixel_t exp_byte;
        bit     zero_path;
        int     ar_before;
        int     aw_before;
        int     n;
        predict(pic, r, exp_byte, zero_path);
        ar_before     = dram.ar_count;
        aw_before     = dram.aw_count;
        in_valid      = 1'b1;
        in_pic_no     = pic;
        in_ratio_mode = r;
        @(posedge clk);
        #1 in_valid = 1'b0;
        // second edge after the capture edge
        @(posedge clk);
        @(posedge clk);
        if (zero_path) begin
            check_bit(out_valid, 1'b1, "out_valid two cycles after a zero-count request");
        end else begin
            check_bit(arvalid & awvalid, 1'b1, "arvalid and awvalid two cycles after request");
            n = 0;
            while (!out_valid && n < REQ_TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (!out_valid) begin
                errors++;
                $display("request on picture %0d gave no result within %0d cycles",
                         pic, REQ_TIMEOUT);
            end
        end
        got = out_data;
        check_out(got, exp_byte, $sformatf("out_data for picture %0d", pic));
        @(posedge clk);
        check_bit(out_valid, 1'b0, "out_valid lasts one cycle");
        #1;
        if (zero_path) begin
            check_bit(dram.ar_count == ar_before && dram.aw_count == aw_before, 1'b1,
                      "no DRAM bursts on a zero count");
        end else begin
            inspect_last_flags();
        end
        check_cnt(UUT.u_table.cnt_q[pic], div_cnt_t'(ref_cnt[pic]), "exposure count");
        check_picture(pic);
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic unity_ratio();
        pixel_t got;
        int     e0;
        e0 = errors;
        load_picture(4'd1, 1'b0, 8'd100);
        run_request(4'd1, 2'd2, got);
        finish_test("unity ratio", e0);
    endtask

    task automatic ratio_scaling();
        pixel_t got;
        int     e0;
        e0 = errors;
        load_picture(4'd2, 1'b1, '0);
        load_picture(4'd3, 1'b1, '0);
        load_picture(4'd4, 1'b1, '0);
        run_request(4'd2, 2'd0, got);
        run_request(4'd3, 2'd1, got);
        run_request(4'd4, 2'd3, got);
        finish_test("ratio scaling", e0);
    endtask

    task automatic count_decay();
        pixel_t got;
        int     e0;
        e0 = errors;
        load_picture(4'd5, 1'b1, '0);
        // 8 6 4 2 0, then the zero-count request
        repeat (5) run_request(4'd5, 2'd0, got);
        finish_test("count decay", e0);
    endtask

    task automatic count_clamp();
        pixel_t got;
        int     e0;
        e0 = errors;
        load_picture(4'd6, 1'b1, '0);
        repeat (2) run_request(4'd6, 2'd3, got);
        // a count above 8 would need a fifth decay step
        repeat (5) run_request(4'd6, 2'd0, got);
        finish_test("count clamp", e0);
    endtask

    task automatic back_pressure();
        pixel_t got;
        int     e0;
        e0 = errors;
        load_picture(4'd7, 1'b1, '0);
        copy_picture(4'd7, 4'd8);
        // same pixels and ratio, so both runs share one expected result
        dram.max_delay = 1;
        run_request(4'd7, 2'd3, got);
        dram.max_delay = 6;
        run_request(4'd8, 2'd3, got);
        dram.max_delay = 1;
        finish_test("back-pressure", e0);
    endtask

    task automatic mid_run_reset();
        pixel_t got;
        int     e0;
        e0 = errors;
        // reset lands while AR and AW still wait for ready
        in_valid      = 1'b1;
        in_pic_no     = 4'd2;
        in_ratio_mode = 2'd1;
        @(posedge clk);
        #1 in_valid = 1'b0;
        @(posedge clk);
        #1;
        check_bit(arvalid & awvalid, 1'b1, "address valids up before the reset");
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check_bit(out_valid | arvalid | awvalid | wvalid | rready | bready, 1'b0,
                  "control outputs after reset");
        for (int i = 0; i < NUM_PICS; i++) begin
            check_cnt(UUT.u_table.cnt_q[i], MAX_DIV_CNT, $sformatf("count %0d after reset", i));
            ref_cnt[i] = int'(MAX_DIV_CNT);
        end
        // picture 5 sat at zero before the reset
        run_request(4'd5, 2'd1, got);
        finish_test("reset", e0);
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------
    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = '0;
        for (int i = 0; i < NUM_PICS; i++) begin
            ref_cnt[i] = int'(MAX_DIV_CNT);
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        unity_ratio();
        ratio_scaling();
        count_decay();
        count_clamp();
        back_pressure();
        mid_run_reset();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out at %0t before all tests finished", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: testbench/dram_model.sv
`timescale 1ns/100ps

module dram_model (
    input  logic               clk,

    input  isp_pkg::axi_addr_t ar,
    input  logic               arvalid,
    output logic               arready,

    output isp_pkg::beat_t     rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,

    input  isp_pkg::axi_addr_t aw,
    input  logic               awvalid,
    output logic               awready,

    input  isp_pkg::w_beat_t   w,
    input  logic               wvalid,
    output logic               wready,

    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready
);
    import isp_pkg::*;

    // byte storage for 16 pictures starting at DRAM_BASE
    pixel_t mem [NUM_PICS*PIC_BYTES];

    // last flag seen on each W beat of the latest burst
    logic w_last_log [BEATS_PER_PIC];

    int max_delay = 1;
    int seed      = 32'he771_9dd6;
    int ar_count  = 0;
    int aw_count  = 0;

    function automatic int pick_delay();
        return $unsigned($random(seed)) % (max_delay + 1);
    endfunction

    // leaves the caller 1 ns past a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ----------------------------------------
    // read side
    // ----------------------------------------
    initial begin : read_side
        addr_t addr;
        int    len;
        int    base;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            do @(posedge clk); while (!arvalid);
            #1;
            wait_cycles(pick_delay());
            arready = 1'b1;
            @(posedge clk);
            addr = ar.addr;
            len  = ar.len;
            ar_count++;
            #1 arready = 1'b0;
            for (int b = 0; b <= len; b++) begin
                wait_cycles(pick_delay());
                base = addr - DRAM_BASE + b * PIXELS_PER_BEAT;
                for (int k = 0; k < PIXELS_PER_BEAT; k++) begin
                    rdata[k*8 +: 8] = mem[base + k];
                end
                rlast  = (b == len);
                rvalid = 1'b1;
                do @(posedge clk); while (!rready);
                #1 rvalid = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // write side
    // ----------------------------------------
    initial begin : write_side
        addr_t addr;
        int    len;
        int    base;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = 2'b00;
        forever begin
            do @(posedge clk); while (!awvalid);
            #1;
            wait_cycles(pick_delay());
            awready = 1'b1;
            @(posedge clk);
            addr = aw.addr;
            len  = aw.len;
            aw_count++;
            #1 awready = 1'b0;
            for (int b = 0; b <= len; b++) begin
                wait_cycles(pick_delay());
                wready = 1'b1;
                do @(posedge clk); while (!wvalid);
                base = addr - DRAM_BASE + b * PIXELS_PER_BEAT;
                for (int k = 0; k < PIXELS_PER_BEAT; k++) begin
                    mem[base + k] = w.data[k*8 +: 8];
                end
                w_last_log[b] = w.last;
                #1 wready = 1'b0;
            end
            wait_cycles(pick_delay());
            bresp  = 2'b00;
            bvalid = 1'b1;
            do @(posedge clk); while (!bready);
            #1 bvalid = 1'b0;
        end
    end

endmodule

// File: src/isp_top.sv
`timescale 1ns/100ps

module isp_top (
    input  logic               clk,
    input  logic               rst_n,

    // host side
    input  logic               in_valid,
    input  isp_pkg::pic_no_t   in_pic_no,
    input  isp_pkg::ratio_t    in_ratio_mode,
    output logic               out_valid,
    output isp_pkg::pixel_t    out_data,

    // read address
    output isp_pkg::axi_addr_t ar,
    output logic               arvalid,
    input  logic               arready,

    // read data
    input  isp_pkg::beat_t     rdata,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready,

    // write address
    output isp_pkg::axi_addr_t aw,
    output logic               awvalid,
    input  logic               awready,

    // write data
    output isp_pkg::w_beat_t   w,
    output logic               wvalid,
    input  logic               wready,

    // write response
    input  logic [1:0]         bresp,
    input  logic               bvalid,
    output logic               bready
);
    import isp_pkg::*;

    pic_no_t   pic_no;
    ratio_t    ratio;
    div_cnt_t  div_cnt;
    logic      div_zero;
    logic      div_update;
    logic      start;
    logic      write_done;
    luma_sum_t luma_sum;

    exposure_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .div_cnt       (div_cnt),
        .div_zero      (div_zero),
        .arready       (arready),
        .awready       (awready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .write_done    (write_done),
        .luma_sum      (luma_sum),
        .pic_no        (pic_no),
        .ratio         (ratio),
        .div_update    (div_update),
        .start         (start),
        .ar            (ar),
        .arvalid       (arvalid),
        .aw            (aw),
        .awvalid       (awvalid),
        .bready        (bready),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    exposure_table u_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .pic_no     (pic_no),
        .ratio      (ratio),
        .div_update (div_update),
        .div_cnt    (div_cnt),
        .div_zero   (div_zero)
    );

    pixel_scaler u_scaler (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .ratio      (ratio),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .wready     (wready),
        .rready     (rready),
        .w          (w),
        .wvalid     (wvalid),
        .write_done (write_done)
    );

    luma_accum u_luma (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .luma_sum (luma_sum)
    );

endmodule

// File: src/luma_accum.sv
`timescale 1ns/100ps

module luma_accum (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  isp_pkg::w_beat_t   w,
    input  logic               wvalid,
    input  logic               wready,
    output isp_pkg::luma_sum_t luma_sum
);
    import isp_pkg::*;

    luma_sum_t sum_q;
    luma_sum_t beat_sum;

    // green weighs twice red or blue
    always_comb begin
        pixel_t pix;
        beat_sum = '0;
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            pix = w.data[i*8 +: 8];
            if (w.channel == CH_GREEN) begin
                beat_sum = beat_sum + luma_sum_t'(pix >> 1);
            end else begin
                beat_sum = beat_sum + luma_sum_t'(pix >> 2);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else if (start) begin
            sum_q <= '0;
        end else if (wvalid && wready) begin
            sum_q <= sum_q + beat_sum;
        end
    end

    assign luma_sum = sum_q;

endmodule

// File: src/pixel_scaler.sv
`timescale 1ns/100ps

module pixel_scaler (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  isp_pkg::ratio_t   ratio,
    input  isp_pkg::beat_t    rdata,
    input  logic              rvalid,
    input  logic              rlast,
    input  logic              wready,
    output logic              rready,
    output isp_pkg::w_beat_t  w,
    output logic              wvalid,
    output logic              write_done
);
    import isp_pkg::*;

    beat_t     hold_q;
    logic      hold_valid_q;
    logic      active_q;
    beat_idx_t beat_idx_q;
    logic      r_fire;
    logic      w_fire;

    function automatic beat_t scale_beat(input beat_t din, input ratio_t r);
        beat_t  dout;
        pixel_t pix;
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            pix = din[i*8 +: 8];
            case (r)
                2'd0: dout[i*8 +: 8] = pix >> 2;
                2'd1: dout[i*8 +: 8] = pix >> 1;
                2'd2: dout[i*8 +: 8] = pix;
                // saturate once the top bit would shift out
                default: dout[i*8 +: 8] = pix[7] ? 8'hff : pix << 1;
            endcase
        end
        return dout;
    endfunction

    // read only into an empty slot or one being drained this cycle
    assign rready = active_q && (!hold_valid_q || wready);
    assign r_fire = rvalid && rready;
    assign w_fire = hold_valid_q && wready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q     <= 1'b0;
            hold_valid_q <= 1'b0;
            beat_idx_q   <= '0;
        end else begin
            if (start) begin
                active_q <= 1'b1;
            end else if (r_fire && rlast) begin
                active_q <= 1'b0;
            end

            if (r_fire) begin
                hold_valid_q <= 1'b1;
            end else if (w_fire) begin
                hold_valid_q <= 1'b0;
            end

            if (start) begin
                beat_idx_q <= '0;
            end else if (w_fire) begin
                beat_idx_q <= beat_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            hold_q <= scale_beat(rdata, ratio);
        end
    end

    // ----------------------------------------
    // W channel
    // ----------------------------------------
    assign w.data    = hold_q;
    assign w.last    = (beat_idx_q == beat_idx_t'(BEATS_PER_PIC - 1));
    assign w.channel = (beat_idx_q < beat_idx_t'(BEATS_PER_CHANNEL))     ? CH_RED   :
                       (beat_idx_q < beat_idx_t'(2 * BEATS_PER_CHANNEL)) ? CH_GREEN :
                                                                           CH_BLUE;
    assign wvalid     = hold_valid_q;
    assign write_done = w_fire && w.last;

endmodule

// File: src/exposure_ctrl.sv
`timescale 1ns/100ps

module exposure_ctrl (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               in_valid,
    input  isp_pkg::pic_no_t   in_pic_no,
    input  isp_pkg::ratio_t    in_ratio_mode,

    input  isp_pkg::div_cnt_t  div_cnt,
    input  logic               div_zero,

    input  logic               arready,
    input  logic               awready,
    input  logic               bvalid,
    input  logic [1:0]         bresp,
    input  logic               write_done,
    input  isp_pkg::luma_sum_t luma_sum,

    output isp_pkg::pic_no_t   pic_no,
    output isp_pkg::ratio_t    ratio,
    output logic               div_update,
    output logic               start,
    output isp_pkg::axi_addr_t ar,
    output logic               arvalid,
    output isp_pkg::axi_addr_t aw,
    output logic               awvalid,
    output logic               bready,
    output logic               out_valid,
    output isp_pkg::pixel_t    out_data
);
    import isp_pkg::*;

    ctrl_state_e state_q;
    pic_no_t     pic_no_q;
    ratio_t      ratio_q;
    logic        arvalid_q;
    logic        awvalid_q;
    logic        done_seen_q;
    logic        out_valid_q;
    pixel_t      out_data_q;

    axi_addr_t   burst;
    logic        ar_clear;
    logic        aw_clear;
    pixel_t      result;

    // ----------------------------------------
    // request capture
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && in_valid) begin
            pic_no_q <= in_pic_no;
            ratio_q  <= in_ratio_mode;
        end
    end

    assign pic_no = pic_no_q;
    assign ratio  = ratio_q;

    // one pulse per nonzero request, table and datapath together
    assign div_update = (state_q == ST_CHECK) && !div_zero;
    assign start      = div_update;

    // one picture per burst, same address for read and write back
    assign burst.addr = DRAM_BASE + addr_t'(pic_no_q) * addr_t'(PIC_BYTES);
    assign burst.len  = burst_len_t'(BEATS_PER_PIC - 1);
    assign ar = burst;
    assign aw = burst;

    assign ar_clear = !arvalid_q || arready;
    assign aw_clear = !awvalid_q || awready;

    // slave error on the write drops the result to zero
    assign result = bresp[1] ? '0 : pixel_t'(luma_sum >> LUMA_SHIFT);

    // ----------------------------------------
    // control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            arvalid_q   <= 1'b0;
            awvalid_q   <= 1'b0;
            done_seen_q <= 1'b0;
            out_valid_q <= 1'b0;
            out_data_q  <= '0;
        end else begin
            out_valid_q <= 1'b0;

            case (state_q)
                ST_IDLE: begin
                    if (in_valid) begin
                        state_q <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (div_zero) begin
                        // count reads zero on this path
                        out_valid_q <= 1'b1;
                        out_data_q  <= pixel_t'(div_cnt);
                        state_q     <= ST_IDLE;
                    end else begin
                        arvalid_q <= 1'b1;
                        awvalid_q <= 1'b1;
                        state_q   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (ar_clear && aw_clear) begin
                        state_q <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (write_done || done_seen_q) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (bvalid) begin
                        out_valid_q <= 1'b1;
                        out_data_q  <= result;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase

            // last W beat can fire before AW is taken
            if (start) begin
                done_seen_q <= 1'b0;
            end else if (write_done) begin
                done_seen_q <= 1'b1;
            end
        end
    end

    assign arvalid   = arvalid_q;
    assign awvalid   = awvalid_q;
    assign bready    = (state_q == ST_RESP);
    assign out_valid = out_valid_q;
    assign out_data  = out_data_q;

endmodule

// File: src/exposure_table.sv
`timescale 1ns/100ps

module exposure_table (
    input  logic              clk,
    input  logic              rst_n,
    input  isp_pkg::pic_no_t  pic_no,
    input  isp_pkg::ratio_t   ratio,
    input  logic              div_update,
    output isp_pkg::div_cnt_t div_cnt,
    output logic              div_zero
);
    import isp_pkg::*;

    div_cnt_t   cnt_q [NUM_PICS];
    div_cnt_t   cur;
    div_cnt_t   cnt_next;
    logic [4:0] raised;
    logic [4:0] lowered;

    assign cur      = cnt_q[pic_no];
    assign div_cnt  = cur;
    assign div_zero = (cur == '0);

    // old + ratio - unity, clamped to 0..max
    assign raised  = {1'b0, cur} + {3'b000, ratio};
    assign lowered = raised - 5'(RATIO_UNITY);

    always_comb begin
        if (raised < 5'(RATIO_UNITY)) begin
            cnt_next = '0;
        end else if (lowered > {1'b0, MAX_DIV_CNT}) begin
            cnt_next = MAX_DIV_CNT;
        end else begin
            cnt_next = div_cnt_t'(lowered);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PICS; i++) begin
                cnt_q[i] <= MAX_DIV_CNT;
            end
        end else if (div_update) begin
            cnt_q[pic_no] <= cnt_next;
        end
    end

endmodule

// File: src/isp_pkg.sv
package isp_pkg;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------
    typedef logic [7:0]   pixel_t;
    typedef logic [127:0] beat_t;
    typedef logic [3:0]   pic_no_t;
    typedef logic [1:0]   ratio_t;
    typedef logic [3:0]   div_cnt_t;
    typedef logic [31:0]  addr_t;
    typedef logic [7:0]   burst_len_t;
    typedef logic [7:0]   beat_idx_t;
    typedef logic [19:0]  luma_sum_t;

    // ----------------------------------------
    // enums
    // ----------------------------------------
    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
    } channel_e;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_CHECK  = 3'd1,
        ST_ADDR   = 3'd2,
        ST_STREAM = 3'd3,
        ST_RESP   = 3'd4
    } ctrl_state_e;

    // ----------------------------------------
    // AXI channel payloads
    // ----------------------------------------
    // shared by AR and AW
    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_addr_t;

    typedef struct packed {
        beat_t    data;
        logic     last;
        channel_e channel;
    } w_beat_t;

    // ----------------------------------------
    // DRAM layout
    // ----------------------------------------
    localparam addr_t    DRAM_BASE         = 32'h0001_0000;
    localparam int       PIC_BYTES         = 3072;
    localparam int       BEATS_PER_PIC     = 192;
    localparam int       BEATS_PER_CHANNEL = 64;
    localparam int       PIXELS_PER_BEAT   = 16;
    localparam int       NUM_PICS          = 16;

    // exposure rules
    localparam div_cnt_t MAX_DIV_CNT       = 4'd8;
    localparam int       RATIO_UNITY       = 2;
    localparam int       LUMA_SHIFT        = 10;

endpackage
